// ==== Bender.yml ====
package:
  name: tile_video

sources:
  - hdl/tile_pkg.sv
  - hdl/video_timing.sv
  - hdl/tile_vram.sv
  - hdl/palette_prom.sv
  - hdl/scroll_layer.sv
  - hdl/tile_video_top.sv
  - target: test
    files:
      - tb/tile_video_tb.sv

// ==== hdl/palette_prom.sv ====
// 256 x 4 colour PROM, loaded through the prog port before use.
// Contents are undefined until loaded; only the output starts at zero.
`timescale 1ns/1ps

module palette_prom (
    input  logic       clk,
    input  logic       cen,
    input  logic [7:0] prog_addr,
    input  logic [3:0] prog_data,
    input  logic       prog_en,
    input  logic [7:0] rd_addr,
    output logic [3:0] q = 4'd0
);

    logic [3:0] mem [256];

    // Loader port, any clk
    always_ff @(posedge clk) begin
        if (prog_en) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // One pixel of delay on the lookup
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];
        end
    end

endmodule

// ==== hdl/scroll_layer.sv ====
// Column scroll tile layer, 8x8 tiles at 4 bpp. Needs a ROM that answers
// within one clk, the fetch window is only two pixel clocks long.
`timescale 1ns/1ps

module scroll_layer
    import tile_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  video_pos_t  pos,
    input  cpu_bus_t    cpu,
    output logic [7:0]  vscr_dout,
    output logic [9:0]  rd_addr,
    input  logic [7:0]  code,
    input  tile_attr_t  attr,
    output rom_addr_t   rom_addr,
    input  logic [31:0] rom_data,
    output logic [7:0]  pal_addr
);

    logic [7:0]  vpos;      // CPU scroll value
    logic [7:0]  vscr;      // Scrolled row for the current line
    logic [7:0]  hdf;       // Column after screen flip
    logic        load_col;
    logic [31:0] pxl_data;
    logic        cur_hf;
    logic [3:0]  cur_pal;

    // Planar ROM word into one nibble per pixel, leftmost pixel on top
    function automatic logic [31:0] planar_to_packed(input logic [31:0] w);
        logic [31:0] r;
        for (int h = 0; h < 2; h++) begin
            for (int n = 0; n < 4; n++) begin
                for (int b = 0; b < 4; b++) begin
                    r[16*h + 15 - 4*n - b] = w[16*h + 15 - n - 4*b];
                end
            end
        end
        return r;
    endfunction

    assign hdf      = pos.hdump[7:0] ^ {8{pos.flip}};
    assign load_col = (pos.hdump[2:0] == 3'd1);  // Map and ROM have settled by now

    assign rd_addr   = {vscr[7:3], hdf[7:3]};
    assign rom_addr  = {attr.code_msb, code, vscr[2:0] ^ {3{attr.vflip}}};
    assign vscr_dout = vscr;

    // Scroll latch, reloaded every clk while its window is open
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vpos <= '0;
            vscr <= '0;
        end else begin
            if (cpu.vscr_cs && cpu.op == cpu_write) begin
                vpos <= cpu.din;
            end
            if (pos.hdump[8]) begin
                vscr <= {8{pos.flip}} ^ pos.vdump;  // Blank, no scroll
            end else if (pos.hdump[4]) begin
                vscr <= {8{pos.flip}} ^ (pos.vdump + vpos);
            end
        end
    end

    // Pattern shifter. Screen flip mirrors each tile on top of hflip
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (load_col) begin
                pxl_data <= planar_to_packed(rom_data);
                cur_hf   <= attr.hflip ^ pos.flip;
                cur_pal  <= attr.pal;
            end else begin
                pxl_data <= cur_hf ? pxl_data >> 4 : pxl_data << 4;
            end
        end
    end

    // Palette row is held per tile so the next fetch cannot recolour it
    assign pal_addr = {cur_pal, cur_hf ? pxl_data[3:0] : pxl_data[31:28]};

    // The ROM word loaded must belong to the address on the bus at load.
    // Scroll writes or a flip change inside the window move it legally
    property rom_addr_held_p;
        @(posedge clk) disable iff (rst)
            (pxl_cen && load_col
                && !$past(cpu.vscr_cs, 2) && !$past(cpu.vscr_cs, 3)
                && $past(pos.flip, 2) == pos.flip)
            |-> $stable(rom_addr);
    endproperty

    assert property (rom_addr_held_p)
        else $error("rom_addr moved during tile load: %h", rom_addr);

endmodule

// ==== hdl/tile_pkg.sv ====
// Shared types for the tile layer. Counts assume a 384 x 264 raster with a
// 256 x 224 visible window; everything runs on one clock domain.
package tile_pkg;

    // Raster size in pixel clocks and lines
    localparam int unsigned h_total  = 384;
    localparam int unsigned v_total  = 264;

    // Blank edges, active from *_end up to *_start
    localparam int unsigned hb_start = 256;
    localparam int unsigned hb_end   = 0;
    localparam int unsigned vb_start = 240;
    localparam int unsigned vb_end   = 16;

    typedef logic [8:0] hdump_t;
    typedef logic [7:0] vdump_t;

    // Graphics ROM word address: code_msb, code, fine row
    typedef logic [12:0] rom_addr_t;

    // Beam position as seen by the renderers
    typedef struct packed {
        hdump_t hdump;
        vdump_t vdump;
        logic   lhbl;   // Low during horizontal blank
        logic   lvbl;   // Low during vertical blank
        logic   flip;   // Screen flip, follows the pixel clock
    } video_pos_t;

    // Attribute byte as stored in the upper map half
    typedef struct packed {
        logic [1:0] code_msb;   // Tile code bits 9..8
        logic       vflip;
        logic       hflip;
        logic [3:0] pal;        // Palette row
    } tile_attr_t;

    typedef enum logic {
        cpu_read  = 1'b0,
        cpu_write = 1'b1
    } cpu_op_e;

    // CPU side of the board, one transfer per clk while a select is high
    typedef struct packed {
        logic [10:0] addr;
        logic [7:0]  din;
        cpu_op_e     op;
        logic        vram_cs;
        logic        vscr_cs;
    } cpu_bus_t;

endpackage

// ==== hdl/tile_video_top.sv ====
// Background layer with timing, map and palette. The graphics ROM sits
// outside; rom_data must follow rom_addr within one clk.
`timescale 1ns/1ps

module tile_video_top
    import tile_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        flip,

    // CPU
    input  cpu_bus_t    cpu,
    output logic [7:0]  vram_dout,
    output logic [7:0]  vscr_dout,

    // Palette loader
    input  logic [7:0]  prog_addr,
    input  logic [3:0]  prog_data,
    input  logic        prog_en,

    // Graphics ROM
    output rom_addr_t   rom_addr,
    input  logic [31:0] rom_data,

    // Display side
    output logic [3:0]  pxl,
    output video_pos_t  pos
);

    logic       pxl_cen;
    logic [9:0] map_addr;
    logic [7:0] map_code;
    tile_attr_t map_attr;
    logic [7:0] pal_addr;

    video_timing i_video_timing (
        .clk     (clk),
        .rst     (rst),
        .flip    (flip),
        .pxl_cen (pxl_cen),
        .pos     (pos)
    );

    tile_vram i_tile_vram (
        .clk       (clk),
        .cpu       (cpu),
        .vram_dout (vram_dout),
        .rd_addr   (map_addr),
        .code      (map_code),
        .attr      (map_attr)
    );

    scroll_layer i_scroll_layer (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pos       (pos),
        .cpu       (cpu),
        .vscr_dout (vscr_dout),
        .rd_addr   (map_addr),
        .code      (map_code),
        .attr      (map_attr),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .pal_addr  (pal_addr)
    );

    palette_prom i_palette_prom (
        .clk       (clk),
        .cen       (pxl_cen),   // Lookup adds one pixel of delay
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .rd_addr   (pal_addr),
        .q         (pxl)
    );

endmodule

// ==== hdl/tile_vram.sv ====
// Tile map, 1K codes plus 1K attributes. CPU addr bit 10 picks the half.
// No read-during-write bypass, a read in a write cycle returns old data.
`timescale 1ns/1ps

module tile_vram
    import tile_pkg::*;
(
    input  logic       clk,
    input  cpu_bus_t   cpu,
    output logic [7:0] vram_dout,
    input  logic [9:0] rd_addr,
    output logic [7:0] code,
    output tile_attr_t attr
);

    logic [7:0] code_mem [1024];
    logic [7:0] attr_mem [1024];
    logic       we;
    logic       we_code;
    logic       we_attr;
    logic [7:0] cpu_code;
    logic [7:0] cpu_attr;
    logic       cpu_hi;     // Half selected by the last CPU access

    assign we      = cpu.vram_cs && (cpu.op == cpu_write);
    assign we_code = we && !cpu.addr[10];
    assign we_attr = we &&  cpu.addr[10];

    // CPU port
    always_ff @(posedge clk) begin
        if (we_code) begin
            code_mem[cpu.addr[9:0]] <= cpu.din;
        end
        if (we_attr) begin
            attr_mem[cpu.addr[9:0]] <= cpu.din;
        end
        if (cpu.vram_cs) begin
            cpu_code <= code_mem[cpu.addr[9:0]];
            cpu_attr <= attr_mem[cpu.addr[9:0]];
            cpu_hi   <= cpu.addr[10];
        end
    end

    assign vram_dout = cpu_hi ? cpu_attr : cpu_code;

    // Renderer port, both halves at once
    always_ff @(posedge clk) begin
        code <= code_mem[rd_addr];
        attr <= tile_attr_t'(attr_mem[rd_addr]);
    end

    // A CPU write meant for another device leaves the map as it was
    assert property (@(posedge clk)
        (cpu.op == cpu_write && !cpu.vram_cs) |=>
            code_mem[$past(cpu.addr[9:0])] == $past(code_mem[cpu.addr[9:0]]) &&
            attr_mem[$past(cpu.addr[9:0])] == $past(attr_mem[cpu.addr[9:0]]))
        else $error("map written without vram_cs");

endmodule

// ==== hdl/video_timing.sv ====
// Pixel clock is clk/2. vdump wraps 0..255 and then repeats 0..7 inside
// vertical blank, since the line counter only exports its low byte.
`timescale 1ns/1ps

module video_timing
    import tile_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flip,
    output logic       pxl_cen,
    output video_pos_t pos
);

    hdump_t     hcnt;
    logic [8:0] vcnt;   // 264 lines need the full 9 bits
    hdump_t     h_nxt;
    logic [8:0] v_nxt;
    logic       lhbl;
    logic       lvbl;
    logic       flip_q;

    // Next beam position for the coming pixel enable
    always_comb begin
        h_nxt = hcnt + 1'b1;
        v_nxt = vcnt;
        if (hcnt == h_total - 1) begin
            h_nxt = '0;
            v_nxt = (vcnt == v_total - 1) ? 9'd0 : vcnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl_cen <= 1'b0;
            hcnt    <= '0;
            vcnt    <= '0;
            lhbl    <= 1'b0;
            lvbl    <= 1'b0;
            flip_q  <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
            if (pxl_cen) begin
                hcnt   <= h_nxt;
                vcnt   <= v_nxt;
                flip_q <= flip;
                // Blank levels are registered with the counters
                lhbl   <= (h_nxt >= hb_end) && (h_nxt < hb_start);
                lvbl   <= (v_nxt >= vb_end) && (v_nxt < vb_start);
            end
        end
    end

    always_comb begin
        pos.hdump = hcnt;
        pos.vdump = vcnt[7:0];
        pos.lhbl  = lhbl;
        pos.lvbl  = lvbl;
        pos.flip  = flip_q;
    end

    // Downstream fetch timing relies on hdump never reaching h_total
    assert property (@(posedge clk) disable iff (rst) pos.hdump < h_total)
        else $error("hdump out of range: %0d", pos.hdump);

endmodule

// ==== tb/tile_video_tb.sv ====
// Directed testbench for the tile layer with a behavioural graphics ROM.
// Pixel checks assume vpos at zero and screen flip off.
`timescale 1ns/1ps

module tile_video_tb
    import tile_pkg::*;
();

    localparam int n_vram     = 16;
    localparam int frame_clks = 2 * h_total * v_total;
    // CPU cycles of palette load, map fills, readback and register writes
    localparam int cpu_clks     = 257 + 4096 + 6 * n_vram + 4 + 4096 + 2;
    localparam int timeout_clks = 3 * frame_clks + cpu_clks;

    logic        clk;
    logic        rst;
    logic        flip;
    cpu_bus_t    cpu;
    logic [7:0]  vram_dout;
    logic [7:0]  vscr_dout;
    logic [7:0]  prog_addr;
    logic [3:0]  prog_data;
    logic        prog_en;
    rom_addr_t   rom_addr;
    logic [31:0] rom_data;
    logic [3:0]  pxl;
    video_pos_t  pos;

    int          seed;
    int          n_errors;
    int          n_checks;
    logic [7:0]  vram_model [2048];
    logic [3:0]  pal_model [256];
    logic [7:0]  vpos_model;

    tile_video_top i_tile_video_top (
        .clk       (clk),
        .rst       (rst),
        .flip      (flip),
        .cpu       (cpu),
        .vram_dout (vram_dout),
        .vscr_dout (vscr_dout),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .pxl       (pxl),
        .pos       (pos)
    );

    always #50 clk = ~clk;

    // Pixel k of the word is (addr + k) mod 16 and sits in four bit planes
    function automatic logic [31:0] rom_word(input rom_addr_t a);
        logic [31:0] w;
        logic [3:0]  pix;
        w = '0;
        for (int k = 0; k < 8; k++) begin
            pix = a[3:0] + 4'(k);
            for (int j = 0; j < 4; j++) begin
                w[16 * (k / 4) + 4 * j + (k % 4)] = pix[j];  // Bit j of pixel k
            end
        end
        return w;
    endfunction

    always @(posedge clk) rom_data <= rom_word(rom_addr);

    function automatic logic [7:0] map_code(input logic [9:0] i);
        return 8'(i * 29 + 11);
    endfunction

    function automatic tile_attr_t map_attr(input logic [9:0] i, input logic hf,
                                            input logic vf);
        tile_attr_t a;
        a.code_msb = i[1:0];
        a.vflip    = vf;
        a.hflip    = hf;
        a.pal      = i[5:2] ^ i[9:6];
        return a;
    endfunction

    // First two tiles still use the row latched in the previous hblank
    function automatic logic [7:0] tile_row(input int line, input int t);
        if (t < 2) begin
            return 8'(line - 1);
        end
        return 8'(line) + vpos_model;
    endfunction

    function automatic rom_addr_t tile_rom(input int line, input int t, input logic hf,
                                           input logic vf);
        logic [7:0] row;
        logic [9:0] i;
        tile_attr_t a;
        row = tile_row(line, t);
        i   = {row[7:3], 5'(t)};
        a   = map_attr(i, hf, vf);
        return {a.code_msb, map_code(i), row[2:0] ^ {3{vf}}};
    endfunction

    function automatic logic [7:0] pal_index(input int line, input int c, input logic hf,
                                             input logic vf);
        logic [7:0] row;
        tile_attr_t a;
        rom_addr_t  ra;
        logic [3:0] nib;
        row = tile_row(line, c / 8);
        a   = map_attr({row[7:3], 5'(c / 8)}, hf, vf);
        ra  = tile_rom(line, c / 8, hf, vf);
        nib = hf ? ra[3:0] + 4'(c % 8) : ra[3:0] + 4'(7 - c % 8);  // Nibble 7 leads
        return {a.pal, nib};
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_attr(input string name, input tile_attr_t got, input tile_attr_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_pixel(input string name, input logic [3:0] got, input logic [3:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch %s: got %h expected %h at hdump %h", name, got, exp, pos.hdump);
        end
    endtask

    task automatic verify_rom_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch %s: got %h expected %h at hdump %h", name, got, exp, pos.hdump);
        end
    endtask

    task automatic compare_pos(input string name, input video_pos_t got, input video_pos_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic cpu_write_byte(input logic [10:0] a, input logic [7:0] d);
        @(posedge clk);
        cpu.addr    <= a;
        cpu.din     <= d;
        cpu.op      <= cpu_write;
        cpu.vram_cs <= 1'b1;
        @(posedge clk);
        cpu.vram_cs <= 1'b0;
        cpu.op      <= cpu_read;
        vram_model[a] = d;
    endtask

    task automatic read_vram(input logic [10:0] a);
        @(posedge clk);
        cpu.addr    <= a;
        cpu.op      <= cpu_read;
        cpu.vram_cs <= 1'b1;
        @(posedge clk);
        cpu.vram_cs <= 1'b0;
        @(negedge clk);             // Data registered on the last edge
    endtask

    task automatic write_vpos(input logic [7:0] v);
        @(posedge clk);
        cpu.addr    <= '0;
        cpu.din     <= v;
        cpu.op      <= cpu_write;
        cpu.vscr_cs <= 1'b1;
        @(posedge clk);
        cpu.vscr_cs <= 1'b0;
        cpu.op      <= cpu_read;
        vpos_model = v;
    endtask

    task automatic write_palette(input logic [7:0] a, input logic [3:0] d);
        @(posedge clk);
        prog_addr <= a;
        prog_data <= d;
        prog_en   <= 1'b1;
        @(posedge clk);
        prog_en   <= 1'b0;
    endtask

    task automatic load_palette();
        logic [7:0] a;
        for (int n = 0; n < 256; n++) begin
            a = 8'(n);
            @(posedge clk);
            prog_addr <= a;
            prog_data <= a[3:0] ^ a[7:4];
            prog_en   <= 1'b1;
            pal_model[a] = a[3:0] ^ a[7:4];
        end
        @(posedge clk);
        prog_en <= 1'b0;
    endtask

    task automatic fill_attrs(input logic hf, input logic vf);
        for (int i = 0; i < 1024; i++) begin
            cpu_write_byte({1'b1, 10'(i)}, map_attr(10'(i), hf, vf));
        end
    endtask

    task automatic fill_map(input logic hf, input logic vf);
        for (int i = 0; i < 1024; i++) begin
            cpu_write_byte({1'b0, 10'(i)}, map_code(10'(i)));
        end
        fill_attrs(hf, vf);
    endtask

    task automatic wait_beam(input int v, input int h);
        do begin
            @(negedge clk);
        end while (!(pos.vdump == v && pos.hdump == h));
    endtask

    task automatic wait_active_h(input int h);
        do begin
            @(negedge clk);
        end while (!(pos.lvbl && pos.hdump == h));
    endtask

    task automatic wait_line_start();
        do begin
            @(negedge clk);
        end while (pos.hdump != 0);
    endtask

    // Column c shows on pxl while hdump is c+3 and tile T loads at hdump 8T+1
    task automatic check_line(input int line, input logic hf, input logic vf);
        video_pos_t p;
        for (int c = 0; c < 256; c++) begin
            wait_beam(line, c + 3);
            // Blank levels follow the raster edges
            p.hdump = 9'(c + 3);
            p.vdump = 8'(line);
            p.lhbl  = (c + 3 < hb_start);
            p.lvbl  = (line >= vb_end) && (line < vb_start);
            p.flip  = 1'b0;
            compare_pos("pos", pos, p);
            if (c % 8 == 6 && c < 248) begin
                verify_rom_addr("rom_addr", rom_addr, tile_rom(line, (c + 2) / 8, hf, vf));
            end
            check_pixel("pxl", pxl, pal_model[pal_index(line, c, hf, vf)]);
        end
    endtask

    task automatic vram_readback();
        logic [10:0] addrs [n_vram];
        for (int n = 0; n < n_vram; n++) begin
            addrs[n] = 11'($random(seed));
            cpu_write_byte(addrs[n], 8'($random(seed)));
        end
        for (int n = 0; n < n_vram; n++) begin
            read_vram(addrs[n]);
            if (addrs[n][10]) begin
                compare_attr("vram_dout", tile_attr_t'(vram_dout),
                             tile_attr_t'(vram_model[addrs[n]]));
            end else begin
                check_byte("vram_dout", vram_dout, vram_model[addrs[n]]);
            end
        end
        // Put the tile map back as it was
        for (int n = 0; n < n_vram; n++) begin
            if (addrs[n][10]) begin
                cpu_write_byte(addrs[n], map_attr(addrs[n][9:0], 1'b0, 1'b0));
            end else begin
                cpu_write_byte(addrs[n], map_code(addrs[n][9:0]));
            end
        end
    endtask

    task automatic scroll_register();
        logic [7:0] v;
        v = 8'($random(seed));
        write_vpos(v);
        wait_line_start();
        wait_active_h(20);
        check_byte("vscr_dout", vscr_dout, 8'(pos.vdump + v));
        wait_beam(pos.vdump, 300);      // Hblank of the same line
        check_byte("vscr_dout", vscr_dout, pos.vdump);
        @(posedge clk);
        flip <= 1'b1;
        do begin
            @(negedge clk);
        end while (!pos.flip);
        wait_line_start();
        wait_active_h(20);
        check_byte("vscr_dout", vscr_dout, 8'(~(pos.vdump + v)));
        wait_beam(pos.vdump, 300);
        check_byte("vscr_dout", vscr_dout, 8'(~pos.vdump));
        @(posedge clk);
        flip <= 1'b0;
        write_vpos(8'd0);
        do begin
            @(negedge clk);
        end while (pos.flip);
    endtask

    task automatic pixel_stream();
        check_line(60, 1'b0, 1'b0);
    endtask

    task automatic hflip_tiles();
        fill_attrs(1'b1, 1'b0);
        check_line(100, 1'b1, 1'b0);
    endtask

    task automatic vflip_tiles();
        fill_attrs(1'b0, 1'b1);
        check_line(140, 1'b0, 1'b1);
    endtask

    // Entry used by column 42 of line 60 is checked again in the next frame
    task automatic palette_rewrite();
        logic [7:0] e;
        logic [3:0] v;
        e = pal_index(60, 42, 1'b0, 1'b1);
        v = ~pal_model[e];
        write_palette(e, v);
        pal_model[e] = v;
        check_line(60, 1'b0, 1'b1);
    endtask

    initial begin
        seed       = 77;
        n_errors   = 0;
        n_checks   = 0;
        vpos_model = '0;
        clk        = 1'b0;
        rst        = 1'b1;
        flip       = 1'b0;
        cpu        = '0;
        prog_addr  = '0;
        prog_data  = '0;
        prog_en    = 1'b0;
        rom_data   = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        load_palette();
        fill_map(1'b0, 1'b0);
        vram_readback();
        scroll_register();
        pixel_stream();
        hflip_tiles();
        vflip_tiles();
        palette_rewrite();
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (timeout_clks) @(posedge clk);
        $display("watchdog ran out after %0d clock cycles", timeout_clks);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/tile_pkg.sv
hdl/video_timing.sv
hdl/tile_vram.sv
hdl/palette_prom.sv
hdl/scroll_layer.sv
hdl/tile_video_top.sv
tb/tile_video_tb.sv
